// File: core_config.svh
/*
 sizing for the integer execution cluster
 CORE_MUL_STEPS must equal CORE_XLEN, as the multiplier retires one product bit per step
*/

`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// data path and instruction width
`define CORE_XLEN 32

// general register file
`define CORE_REG_COUNT 32
`define CORE_REG_AW 5

// shift-add iterations per multiply
`define CORE_MUL_STEPS 32

`endif

// File: core_pkg.sv
/*
 shared instruction views and ALU operation codes
 only the RV32 OP and OP-IMM major opcodes are decoded
*/

package core_pkg;

    // R-type field layout
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_r_t;

    // I-type field layout, same register fields as R-type
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_i_t;

    // one instruction word, read as either format
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_u;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    // funct7 of the M extension group
    localparam logic [6:0] F7_MULDIV  = 7'b0000001;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_e;

endpackage

// File: decode_issue.sv
/*
 register file, decode and issue for one instruction in flight
 inst_i is taken when inst_valid_i is high and busy_o is low; hold it otherwise
 x0 reads zero only because writeback never writes entry 0
*/

`timescale 1ns/1ps

`include "core_config.svh"

module decode_issue (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic                    inst_valid_i,
    input  core_pkg::inst_u         inst_i,
    input  logic                    rf_we_i,
    input  logic [`CORE_REG_AW-1:0] rf_waddr_i,
    input  logic [`CORE_XLEN-1:0]   rf_wdata_i,
    input  logic                    retire_i,
    output logic                    busy_o,
    output logic                    illegal_o,
    output logic                    alu_start_o,
    output core_pkg::alu_op_e       alu_op_o,
    output logic                    mul_start_o,
    output logic [`CORE_XLEN-1:0]   op_a_o,
    output logic [`CORE_XLEN-1:0]   op_b_o,
    output logic [`CORE_REG_AW-1:0] rd_o
);

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    logic [`CORE_XLEN-1:0] rf_q [`CORE_REG_COUNT];

    logic                    accept;
    logic                    dec_legal;
    logic                    dec_mul;
    logic                    dec_use_imm;
    core_pkg::alu_op_e       dec_op;
    logic [`CORE_XLEN-1:0]   dec_imm;

    // decoded fields held between accept and issue
    logic                    busy_q;
    logic                    issue_q;
    logic                    is_mul_q;
    logic                    use_imm_q;
    core_pkg::alu_op_e       op_q;
    logic [`CORE_REG_AW-1:0] rs1_q;
    logic [`CORE_REG_AW-1:0] rs2_q;
    logic [`CORE_REG_AW-1:0] rd_q;
    logic [`CORE_XLEN-1:0]   imm_q;

    // funct3 to operation, shared by both formats
    function automatic core_pkg::alu_op_e base_op(input logic [2:0] funct3);
        case (funct3)
            3'b000:  return core_pkg::ALU_ADD;
            3'b001:  return core_pkg::ALU_SLL;
            3'b010:  return core_pkg::ALU_SLT;
            3'b011:  return core_pkg::ALU_SLTU;
            3'b100:  return core_pkg::ALU_XOR;
            3'b101:  return core_pkg::ALU_SRL;
            3'b110:  return core_pkg::ALU_OR;
            default: return core_pkg::ALU_AND;
        endcase
    endfunction

    assign accept  = inst_valid_i && !busy_q;
    assign dec_imm = {{(`CORE_XLEN-12){inst_i.i.imm[11]}}, inst_i.i.imm};

    always_comb begin
        dec_legal   = 1'b0;
        dec_mul     = 1'b0;
        dec_use_imm = 1'b0;
        dec_op      = core_pkg::ALU_ADD;
        case (inst_i.r.opcode)
            core_pkg::OPC_OP: begin
                if (inst_i.r.funct7 == core_pkg::F7_MULDIV) begin
                    // only MUL, the low product word
                    dec_mul   = 1'b1;
                    dec_legal = (inst_i.r.funct3 == 3'b000);
                end else if (inst_i.r.funct7 == F7_BASE) begin
                    dec_legal = 1'b1;
                    dec_op    = base_op(inst_i.r.funct3);
                end else if (inst_i.r.funct7 == F7_ALT) begin
                    if (inst_i.r.funct3 == 3'b000) begin
                        dec_legal = 1'b1;
                        dec_op    = core_pkg::ALU_SUB;
                    end else if (inst_i.r.funct3 == 3'b101) begin
                        dec_legal = 1'b1;
                        dec_op    = core_pkg::ALU_SRA;
                    end
                end
            end
            core_pkg::OPC_OP_IMM: begin
                dec_use_imm = 1'b1;
                dec_op      = base_op(inst_i.i.funct3);
                case (inst_i.i.funct3)
                    3'b001: dec_legal = (inst_i.i.imm[11:5] == F7_BASE);
                    3'b101: begin
                        // imm[11:5] picks logical or arithmetic
                        if (inst_i.i.imm[11:5] == F7_BASE) begin
                            dec_legal = 1'b1;
                        end else if (inst_i.i.imm[11:5] == F7_ALT) begin
                            dec_legal = 1'b1;
                            dec_op    = core_pkg::ALU_SRA;
                        end
                    end
                    default: dec_legal = 1'b1;
                endcase
            end
            default: dec_legal = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < `CORE_REG_COUNT; i++) begin
                rf_q[i] <= '0;
            end
        end else if (rf_we_i) begin
            rf_q[rf_waddr_i] <= rf_wdata_i;
        end
    end

    // control state
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy_q      <= 1'b0;
            issue_q     <= 1'b0;
            illegal_o   <= 1'b0;
            alu_start_o <= 1'b0;
            mul_start_o <= 1'b0;
        end else begin
            if (retire_i) begin
                busy_q <= 1'b0;
            end else if (accept) begin
                busy_q <= dec_legal;
            end
            issue_q     <= accept && dec_legal;
            illegal_o   <= accept && !dec_legal;
            alu_start_o <= issue_q && !is_mul_q;
            mul_start_o <= issue_q && is_mul_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            is_mul_q  <= dec_mul;
            use_imm_q <= dec_use_imm;
            op_q      <= dec_op;
            rs1_q     <= inst_i.r.rs1;
            rs2_q     <= inst_i.r.rs2;
            rd_q      <= inst_i.r.rd;
            imm_q     <= dec_imm;
        end
        // operand read one cycle after accept
        if (issue_q) begin
            alu_op_o <= op_q;
            op_a_o   <= rf_q[rs1_q];
            op_b_o   <= use_imm_q ? imm_q : rf_q[rs2_q];
            rd_o     <= rd_q;
        end
    end

    assign busy_o = busy_q;

    // each start lies inside the busy period of its own instruction
    assert property (@(posedge clk_i) disable iff (reset_i)
        (alu_start_o || mul_start_o) |-> busy_q && !retire_i);

    // retire only ends an instruction that was issued
    assert property (@(posedge clk_i) disable iff (reset_i)
        retire_i |-> busy_q);

endmodule

// File: alu_unit.sv
/*
 single-cycle integer ALU with registered result
 shift amounts use b_i[4:0]; done_o pulses the cycle after start_i
*/

`timescale 1ns/1ps

`include "core_config.svh"

module alu_unit (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic                    start_i,
    input  core_pkg::alu_op_e       op_i,
    input  logic [`CORE_XLEN-1:0]   a_i,
    input  logic [`CORE_XLEN-1:0]   b_i,
    input  logic [`CORE_REG_AW-1:0] rd_i,
    output logic                    done_o,
    output logic [`CORE_XLEN-1:0]   result_o,
    output logic [`CORE_REG_AW-1:0] rd_o
);

    logic [4:0]            shamt;
    logic                  lt_signed;
    logic                  lt_unsigned;
    logic [`CORE_XLEN-1:0] result_d;

    assign shamt       = b_i[4:0];
    assign lt_signed   = $signed(a_i) < $signed(b_i);
    assign lt_unsigned = a_i < b_i;

    always_comb begin
        case (op_i)
            core_pkg::ALU_ADD:  result_d = a_i + b_i;
            core_pkg::ALU_SUB:  result_d = a_i - b_i;
            core_pkg::ALU_AND:  result_d = a_i & b_i;
            core_pkg::ALU_OR:   result_d = a_i | b_i;
            core_pkg::ALU_XOR:  result_d = a_i ^ b_i;
            core_pkg::ALU_SLL:  result_d = a_i << shamt;
            core_pkg::ALU_SRL:  result_d = a_i >> shamt;
            core_pkg::ALU_SRA:  result_d = $unsigned($signed(a_i) >>> shamt);
            core_pkg::ALU_SLT:  result_d = {{(`CORE_XLEN-1){1'b0}}, lt_signed};
            core_pkg::ALU_SLTU: result_d = {{(`CORE_XLEN-1){1'b0}}, lt_unsigned};
            default:            result_d = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            done_o <= 1'b0;
        end else begin
            done_o <= start_i;
        end
    end

    // result and rd only matter while done_o is high
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            result_o <= result_d;
            rd_o     <= rd_i;
        end
    end

endmodule

// File: mul_unit.sv
/*
 iterative shift-add multiplier, low product word only
 one multiplier bit per cycle, done_o pulses CORE_MUL_STEPS + 1 cycles after start_i
 start_i must not arrive while a multiply is running
*/

`timescale 1ns/1ps

`include "core_config.svh"

module mul_unit (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic                    start_i,
    input  logic [`CORE_XLEN-1:0]   a_i,
    input  logic [`CORE_XLEN-1:0]   b_i,
    input  logic [`CORE_REG_AW-1:0] rd_i,
    output logic                    done_o,
    output logic [`CORE_XLEN-1:0]   result_o,
    output logic [`CORE_REG_AW-1:0] rd_o
);

    localparam int STEP_W = $clog2(`CORE_MUL_STEPS);
    localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(`CORE_MUL_STEPS - 1);

    logic                  running_q;
    logic [STEP_W-1:0]     step_q;
    logic [`CORE_XLEN-1:0] acc_q;
    logic [`CORE_XLEN-1:0] mcand_q;
    logic [`CORE_XLEN-1:0] mplier_q;
    logic [`CORE_XLEN-1:0] acc_d;

    // add the shifted multiplicand when the current multiplier bit is set
    assign acc_d = mplier_q[0] ? acc_q + mcand_q : acc_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            running_q <= 1'b0;
            step_q    <= '0;
            done_o    <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                running_q <= 1'b1;
                step_q    <= '0;
            end else if (running_q) begin
                step_q <= step_q + 1'b1;
                if (step_q == LAST_STEP) begin
                    running_q <= 1'b0;
                    done_o    <= 1'b1;
                end
            end
        end
    end

    // datapath
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            acc_q    <= '0;
            mcand_q  <= a_i;
            mplier_q <= b_i;
            rd_o     <= rd_i;
        end else if (running_q) begin
            acc_q    <= acc_d;
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    assign result_o = acc_q;

    assert property (@(posedge clk_i) disable iff (reset_i)
        start_i |-> !running_q);

endmodule

// File: writeback.sv
/*
 commit stage for the ALU and multiplier results
 at most one unit finishes per cycle; writes to x0 are dropped and reported as data 0
*/

`timescale 1ns/1ps

`include "core_config.svh"

module writeback (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic                    alu_done_i,
    input  logic [`CORE_XLEN-1:0]   alu_result_i,
    input  logic [`CORE_REG_AW-1:0] alu_rd_i,
    input  logic                    mul_done_i,
    input  logic [`CORE_XLEN-1:0]   mul_result_i,
    input  logic [`CORE_REG_AW-1:0] mul_rd_i,
    output logic                    rf_we_o,
    output logic [`CORE_REG_AW-1:0] rf_waddr_o,
    output logic [`CORE_XLEN-1:0]   rf_wdata_o,
    output logic                    retire_o,
    output logic                    commit_valid_o,
    output logic [`CORE_REG_AW-1:0] commit_rd_o,
    output logic [`CORE_XLEN-1:0]   commit_data_o
);

    logic                    wb_valid;
    logic [`CORE_REG_AW-1:0] wb_rd;
    logic [`CORE_XLEN-1:0]   wb_data;
    logic                    rd_is_x0;

    assign wb_valid = alu_done_i || mul_done_i;
    assign wb_rd    = mul_done_i ? mul_rd_i : alu_rd_i;
    assign wb_data  = mul_done_i ? mul_result_i : alu_result_i;
    assign rd_is_x0 = (wb_rd == '0);

    // register file write, skipped for x0
    assign rf_we_o    = wb_valid && !rd_is_x0;
    assign rf_waddr_o = wb_rd;
    assign rf_wdata_o = wb_data;

    // every commit retires, x0 included
    assign retire_o       = wb_valid;
    assign commit_valid_o = wb_valid;
    assign commit_rd_o    = wb_rd;
    assign commit_data_o  = rd_is_x0 ? '0 : wb_data;

    assert property (@(posedge clk_i) disable iff (reset_i)
        !(alu_done_i && mul_done_i));

endmodule

// File: exec_core_top.sv
/*
 integer execution cluster: decode and issue, ALU, multiplier, writeback
 one instruction in flight; present inst_i with inst_valid_i and hold it while busy_o is high
*/

`timescale 1ns/1ps

`include "core_config.svh"

module exec_core_top (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic                    inst_valid_i,
    input  logic [`CORE_XLEN-1:0]   inst_i,
    output logic                    busy_o,
    output logic                    illegal_o,
    output logic                    commit_valid_o,
    output logic [`CORE_REG_AW-1:0] commit_rd_o,
    output logic [`CORE_XLEN-1:0]   commit_data_o
);

    core_pkg::inst_u inst_w;

    // issue to the units
    logic                    alu_start;
    core_pkg::alu_op_e       alu_op;
    logic                    mul_start;
    logic [`CORE_XLEN-1:0]   op_a;
    logic [`CORE_XLEN-1:0]   op_b;
    logic [`CORE_REG_AW-1:0] issue_rd;

    // unit results
    logic                    alu_done;
    logic [`CORE_XLEN-1:0]   alu_result;
    logic [`CORE_REG_AW-1:0] alu_rd;
    logic                    mul_done;
    logic [`CORE_XLEN-1:0]   mul_result;
    logic [`CORE_REG_AW-1:0] mul_rd;

    // writeback to the register file
    logic                    rf_we;
    logic [`CORE_REG_AW-1:0] rf_waddr;
    logic [`CORE_XLEN-1:0]   rf_wdata;
    logic                    retire;

    assign inst_w = core_pkg::inst_u'(inst_i);

    decode_issue u_decode_issue (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .inst_valid_i(inst_valid_i),
        .inst_i      (inst_w),
        .rf_we_i     (rf_we),
        .rf_waddr_i  (rf_waddr),
        .rf_wdata_i  (rf_wdata),
        .retire_i    (retire),
        .busy_o      (busy_o),
        .illegal_o   (illegal_o),
        .alu_start_o (alu_start),
        .alu_op_o    (alu_op),
        .mul_start_o (mul_start),
        .op_a_o      (op_a),
        .op_b_o      (op_b),
        .rd_o        (issue_rd)
    );

    alu_unit u_alu_unit (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .start_i (alu_start),
        .op_i    (alu_op),
        .a_i     (op_a),
        .b_i     (op_b),
        .rd_i    (issue_rd),
        .done_o  (alu_done),
        .result_o(alu_result),
        .rd_o    (alu_rd)
    );

    mul_unit u_mul_unit (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .start_i (mul_start),
        .a_i     (op_a),
        .b_i     (op_b),
        .rd_i    (issue_rd),
        .done_o  (mul_done),
        .result_o(mul_result),
        .rd_o    (mul_rd)
    );

    writeback u_writeback (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .alu_done_i    (alu_done),
        .alu_result_i  (alu_result),
        .alu_rd_i      (alu_rd),
        .mul_done_i    (mul_done),
        .mul_result_i  (mul_result),
        .mul_rd_i      (mul_rd),
        .rf_we_o       (rf_we),
        .rf_waddr_o    (rf_waddr),
        .rf_wdata_o    (rf_wdata),
        .retire_o      (retire),
        .commit_valid_o(commit_valid_o),
        .commit_rd_o   (commit_rd_o),
        .commit_data_o (commit_data_o)
    );

endmodule

// File: tb_clock_gen.sv
/*
 free-running testbench clock, starts low
 HALF_NS is half the clock period in ns
*/

`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_NS = 50
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(HALF_NS) clk_o = ~clk_o;
    end

endmodule

// File: exec_core_tb.sv
/*
 testbench for exec_core_top, inputs driven 5 ns after each rising edge
 commits are compared at the falling edge against a model register file
 words are treated as illegal only by opcode, funct3 and funct7 as in RV32IM
*/

`timescale 1ns/1ps

`include "core_config.svh"

module exec_core_tb;

    localparam int RESET_CYCLES = 4;
    localparam int N_LOADS      = 8;
    localparam int N_ALU        = 40;
    localparam int N_MUL        = 10;
    localparam int N_X0         = 3;
    localparam int N_ILLEGAL    = 6;
    localparam int N_BP         = 16;
    localparam int N_INST       = 1 + N_LOADS + N_ALU + N_MUL + N_X0 + 2 * N_ILLEGAL + N_BP;
    localparam int TIMEOUT_CYCLES = N_INST * (`CORE_MUL_STEPS + 6) + 100;

    logic                    clk;
    logic                    rst;
    logic                    inst_valid;
    logic [`CORE_XLEN-1:0]   inst;
    logic                    busy;
    logic                    illegal;
    logic                    commit_valid;
    logic [`CORE_REG_AW-1:0] commit_rd;
    logic [`CORE_XLEN-1:0]   commit_data;

    logic [`CORE_XLEN-1:0]   model_rf [`CORE_REG_COUNT];
    int                      seed = 46;
    int                      edge_cnt = 0;
    string                   test_name;

    // one entry per accepted instruction, in issue order
    logic [`CORE_REG_AW-1:0] exp_rd_q [$];
    logic [`CORE_XLEN-1:0]   exp_data_q [$];
    int                      exp_edge_q [$];
    string                   exp_name_q [$];
    int                      illegal_edge_q [$];

    tb_clock_gen u_clock (
        .clk_o(clk)
    );

    exec_core_top dut0 (
        .clk_i         (clk),
        .reset_i       (rst),
        .inst_valid_i  (inst_valid),
        .inst_i        (inst),
        .busy_o        (busy),
        .illegal_o     (illegal),
        .commit_valid_o(commit_valid),
        .commit_rd_o   (commit_rd),
        .commit_data_o (commit_data)
    );

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            abort_run();
        end
    endtask

    function automatic logic [31:0] enc_r(input logic [6:0] funct7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] funct3,
                                          input logic [4:0] rd);
        return {funct7, rs2, rs1, funct3, rd, core_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] funct3, input logic [4:0] rd);
        return {imm, rs1, funct3, rd, core_pkg::OPC_OP_IMM};
    endfunction

    // RV32 legality for the kept subset
    function automatic bit ref_legal(input logic [31:0] word);
        logic [2:0] funct3;
        logic [6:0] funct7;
        funct3 = word[14:12];
        funct7 = word[31:25];
        if (word[6:0] == core_pkg::OPC_OP) begin
            if (funct7 == core_pkg::F7_MULDIV) return funct3 == 3'b000;
            if (funct7 == 7'h00) return 1'b1;
            return funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101);
        end
        if (word[6:0] == core_pkg::OPC_OP_IMM) begin
            if (funct3 == 3'b001) return funct7 == 7'h00;
            if (funct3 == 3'b101) return funct7 == 7'h00 || funct7 == 7'h20;
            return 1'b1;
        end
        return 1'b0;
    endfunction

    // expected result from the model registers, before rd is written
    function automatic logic [31:0] ref_result(input logic [31:0] word);
        logic        is_reg;
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        logic [31:0] res;
        is_reg = (word[6:0] == core_pkg::OPC_OP);
        a      = model_rf[word[19:15]];
        b      = is_reg ? model_rf[word[24:20]] : {{20{word[31]}}, word[31:20]};
        sh     = b[4:0];
        case (word[14:12])
            3'b000: begin
                if (is_reg && word[31:25] == core_pkg::F7_MULDIV) res = a * b;
                else if (is_reg && word[30]) res = a - b;
                else res = a + b;
            end
            3'b001: res = a << sh;
            // signs differ means the negative one is smaller
            3'b010: res = (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            3'b011: res = {31'b0, a < b};
            3'b100: res = a ^ b;
            3'b101: res = (a >> sh) | ((word[30] && a[31]) ? ~(32'hffff_ffff >> sh) : 32'h0);
            3'b110: res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    function automatic logic [31:0] rand_alu_word();
        logic [31:0] r;
        int          pick;
        r    = $random(seed);
        pick = {$random(seed)} % 19;
        case (pick)
            0:  return enc_r(7'h00, r[14:10], r[9:5], 3'b000, r[4:0]);
            1:  return enc_r(7'h20, r[14:10], r[9:5], 3'b000, r[4:0]);
            2:  return enc_r(7'h00, r[14:10], r[9:5], 3'b001, r[4:0]);
            3:  return enc_r(7'h00, r[14:10], r[9:5], 3'b010, r[4:0]);
            4:  return enc_r(7'h00, r[14:10], r[9:5], 3'b011, r[4:0]);
            5:  return enc_r(7'h00, r[14:10], r[9:5], 3'b100, r[4:0]);
            6:  return enc_r(7'h00, r[14:10], r[9:5], 3'b101, r[4:0]);
            7:  return enc_r(7'h20, r[14:10], r[9:5], 3'b101, r[4:0]);
            8:  return enc_r(7'h00, r[14:10], r[9:5], 3'b110, r[4:0]);
            9:  return enc_r(7'h00, r[14:10], r[9:5], 3'b111, r[4:0]);
            10: return enc_i(r[26:15], r[9:5], 3'b000, r[4:0]);
            11: return enc_i(r[26:15], r[9:5], 3'b010, r[4:0]);
            12: return enc_i(r[26:15], r[9:5], 3'b011, r[4:0]);
            13: return enc_i(r[26:15], r[9:5], 3'b100, r[4:0]);
            14: return enc_i(r[26:15], r[9:5], 3'b110, r[4:0]);
            15: return enc_i(r[26:15], r[9:5], 3'b111, r[4:0]);
            16: return enc_i({7'h00, r[19:15]}, r[9:5], 3'b001, r[4:0]);
            17: return enc_i({7'h00, r[19:15]}, r[9:5], 3'b101, r[4:0]);
            default: return enc_i({7'h20, r[19:15]}, r[9:5], 3'b101, r[4:0]);
        endcase
    endfunction

    function automatic logic [31:0] rand_mul_word();
        logic [31:0] r;
        r = $random(seed);
        return enc_r(core_pkg::F7_MULDIV, r[14:10], r[9:5], 3'b000, r[4:0]);
    endfunction

    function automatic logic [31:0] rand_illegal_word();
        logic [31:0] w;
        logic [31:0] r;
        w = $random(seed);
        while (w[6:0] == core_pkg::OPC_OP || w[6:0] == core_pkg::OPC_OP_IMM) begin
            r      = $random(seed);
            w[6:0] = r[6:0];
        end
        return w;
    endfunction

    // present a word until accepted; with hold, inst_valid stays high afterwards
    task automatic issue(input logic [31:0] word, input bit hold);
        logic [31:0] res;
        int          lat;
        inst       = word;
        inst_valid = 1'b1;
        while (busy !== 1'b0) begin
            @(posedge clk);
            #5;
        end
        // the coming edge is the accept edge
        if (ref_legal(word)) begin
            lat = (word[6:0] == core_pkg::OPC_OP && word[31:25] == core_pkg::F7_MULDIV) ?
                  `CORE_MUL_STEPS + 2 : 2;
            res = ref_result(word);
            if (word[11:7] == 5'd0) res = '0;
            else model_rf[word[11:7]] = res;
            exp_rd_q.push_back(word[11:7]);
            exp_data_q.push_back(res);
            exp_edge_q.push_back(edge_cnt + 1 + lat);
            exp_name_q.push_back(test_name);
        end else begin
            illegal_edge_q.push_back(edge_cnt + 1);
        end
        @(posedge clk);
        #5;
        if (!hold) inst_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (exp_rd_q.size() != 0 || illegal_edge_q.size() != 0 || busy !== 1'b0) begin
            @(posedge clk);
            #5;
        end
    endtask

    task automatic check_quiet(input string when);
        check_value({when, " busy_o"}, 32'd0, {31'b0, busy});
        check_value({when, " commit_valid_o"}, 32'd0, {31'b0, commit_valid});
        check_value({when, " illegal_o"}, 32'd0, {31'b0, illegal});
    endtask

    always @(negedge clk) begin : compare_proc
        string name;
        logic [`CORE_REG_AW-1:0] e_rd;
        logic [`CORE_XLEN-1:0]   e_data;
        int                      e_edge;
        if (!rst && commit_valid) begin
            if (exp_rd_q.size() == 0) begin
                $display("commit to x%0d with no instruction outstanding", commit_rd);
                abort_run();
            end
            name   = exp_name_q.pop_front();
            e_rd   = exp_rd_q.pop_front();
            e_data = exp_data_q.pop_front();
            e_edge = exp_edge_q.pop_front();
            check_value({name, " commit rd"}, {27'b0, e_rd}, {27'b0, commit_rd});
            check_value({name, " commit data"}, e_data, commit_data);
            check_value({name, " commit edge"}, e_edge, edge_cnt);
        end
        if (!rst && illegal) begin
            if (illegal_edge_q.size() == 0) begin
                $display("illegal_o pulsed although no illegal word was issued");
                abort_run();
            end
            e_edge = illegal_edge_q.pop_front();
            check_value("illegal pulse edge", e_edge, edge_cnt);
        end
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles, the DUT stopped making progress", TIMEOUT_CYCLES);
        abort_run();
    end

    initial begin : stimulus
        logic [31:0] r;
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        for (int i = 0; i < `CORE_REG_COUNT; i++) model_rf[i] = '0;

        test_name = "reset";
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #5;
            check_quiet("during reset");
        end
        rst = 1'b0;
        @(posedge clk);
        #5;
        check_quiet("after reset");
        r = $random(seed);
        issue(enc_i(r[11:0], 5'd0, 3'b000, 5'd1), 0);
        wait_idle();

        test_name = "alu";
        for (int i = 1; i <= N_LOADS; i++) begin
            r = $random(seed);
            issue(enc_i(r[11:0], 5'd0, 3'b000, 5'(i)), 0);
        end
        for (int i = 0; i < N_ALU; i++) issue(rand_alu_word(), 0);
        wait_idle();

        test_name = "mul";
        for (int i = 0; i < N_MUL; i++) issue(rand_mul_word(), 0);
        wait_idle();

        test_name = "x0";
        issue(enc_i(12'h123, 5'd5, 3'b000, 5'd0), 0);
        issue(enc_r(core_pkg::F7_MULDIV, 5'd4, 5'd3, 3'b000, 5'd0), 0);
        issue(enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd11), 0);
        wait_idle();

        test_name = "illegal";
        for (int i = 0; i < N_ILLEGAL; i++) begin
            issue(rand_illegal_word(), 0);
            check_value("illegal busy_o", 32'd0, {31'b0, busy});
            // copy a register onto itself to read it back
            r = $random(seed);
            issue(enc_i(12'h000, r[4:0], 3'b000, r[4:0]), 0);
        end
        wait_idle();

        test_name = "backpressure";
        for (int i = 0; i < N_BP; i++) begin
            issue((i % 4 == 3) ? rand_mul_word() : rand_alu_word(), 1);
        end
        inst_valid = 1'b0;
        wait_idle();

        repeat (4) @(posedge clk);
        if (exp_rd_q.size() != 0 || illegal_edge_q.size() != 0) begin
            $display("instructions were left without a commit at the end of the run");
            abort_run();
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

// File: filelist.f
+incdir+.
core_pkg.sv
decode_issue.sv
alu_unit.sv
mul_unit.sv
writeback.sv
exec_core_top.sv
tb_clock_gen.sv
exec_core_tb.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator; exits 1 on failure
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal --top-module exec_core_tb \
    -f filelist.f -o exec_core_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

# the simulator exit status is not used, the log decides
./obj_dir/exec_core_sim > sim.log 2>&1 || echo "simulator returned a non-zero status"
cat sim.log

grep -q "=== FAIL ===" sim.log && { echo "simulation failed"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
